// File: axi_ram_cfg.svh
`ifndef AXI_RAM_CFG_SVH
`define AXI_RAM_CFG_SVH

// bus widths in bits
`define AXI_RAM_DW 32
`define AXI_RAM_AW 32

// first byte address of the window
`define AXI_RAM_BASE 'h1000

// memory depth in words
`define AXI_RAM_WORDS 256

// response codes on bresp / rresp
`define AXI_RAM_RESP_OKAY   2'd0
`define AXI_RAM_RESP_SLVERR 2'd2  // write refused
`define AXI_RAM_RESP_DECERR 2'd3  // outside the window

`endif

// File: axi_lite_pkg.sv
`default_nettype none

`include "axi_ram_cfg.svh"

package axi_lite_pkg;

  // byte address as seen on awaddr / araddr
  typedef logic [`AXI_RAM_AW-1:0] addr_t;

  // one data beat
  typedef logic [`AXI_RAM_DW-1:0] data_t;

  typedef logic [`AXI_RAM_DW/8-1:0] strb_t;  // one bit per byte lane

  typedef logic [1:0] resp_t;  // OKAY / SLVERR / DECERR

endpackage

`default_nettype wire

// File: ram_pkg.sv
`default_nettype none

`include "axi_ram_cfg.svh"

package ram_pkg;

  typedef logic [$clog2(`AXI_RAM_WORDS)-1:0] word_addr_t;  // word index into the array

  typedef logic [`AXI_RAM_DW/8-1:0] byte_en_t;

  // one transaction at a time
  typedef enum logic [1:0] {
    IDLE,
    MEM_ACCESS,  // command on the memory port, response unit loads
    RESP_WAIT    // waiting for the B or R handshake
  } arb_state_e;

endpackage

`default_nettype wire

// File: axi_req_arbiter.sv
`default_nettype none

`include "axi_ram_cfg.svh"

module axi_req_arbiter #(
  parameter bit ALLOW_WRITES = 1'b1
) (
  input  logic                     clk_i,
  input  logic                     arst_ni,
  input  logic                     awvalid_i,
  input  axi_lite_pkg::addr_t      awaddr_i,
  input  logic                     wvalid_i,
  input  axi_lite_pkg::data_t      wdata_i,
  input  axi_lite_pkg::strb_t      wstrb_i,
  input  logic                     arvalid_i,
  input  axi_lite_pkg::addr_t      araddr_i,
  output logic                     awready_o,
  output logic                     wready_o,
  output logic                     arready_o,
  output logic                     mem_req_o,
  output logic                     mem_we_o,
  output ram_pkg::word_addr_t      mem_addr_o,
  output axi_lite_pkg::data_t      mem_wdata_o,
  output ram_pkg::byte_en_t        mem_be_o,
  output logic                     resp_start_o,
  output logic                     resp_is_read_o,
  output axi_lite_pkg::resp_t      resp_code_o,
  input  logic                     resp_done_i
);

  localparam int unsigned WordLsb   = $clog2(`AXI_RAM_DW / 8);
  localparam int unsigned WordAw    = $bits(ram_pkg::word_addr_t);
  localparam int unsigned SpanBytes = `AXI_RAM_WORDS * (`AXI_RAM_DW / 8);

  localparam axi_lite_pkg::addr_t Base = axi_lite_pkg::addr_t'(`AXI_RAM_BASE);

  ram_pkg::arb_state_e state_q, state_d;

  logic last_rd_q;  // kind served last, for alternation
  logic wr_pend;
  logic rd_pend;
  logic grant_wr;
  logic grant_rd;

  axi_lite_pkg::addr_t req_addr;
  axi_lite_pkg::addr_t offset;
  logic                in_range;
  axi_lite_pkg::resp_t code_d;

  logic                is_rd_q;
  axi_lite_pkg::resp_t code_q;
  ram_pkg::word_addr_t addr_q;
  axi_lite_pkg::data_t wdata_q;
  ram_pkg::byte_en_t   be_q;

  // a write needs both address and data
  assign wr_pend = awvalid_i && wvalid_i;
  assign rd_pend = arvalid_i;

  always_comb begin
    grant_wr = 1'b0;
    grant_rd = 1'b0;
    if (state_q == ram_pkg::IDLE) begin
      grant_wr = wr_pend && (!rd_pend || last_rd_q);
      grant_rd = rd_pend && !grant_wr;
    end
  end

  assign awready_o = grant_wr;
  assign wready_o  = grant_wr;
  assign arready_o = grant_rd;

  // address decode against the window
  assign req_addr = grant_wr ? awaddr_i : araddr_i;
  assign offset   = req_addr - Base;
  assign in_range = (req_addr >= Base) && (offset < SpanBytes);

  always_comb begin
    if (!in_range) begin
      code_d = `AXI_RAM_RESP_DECERR;
    end else if (grant_wr && !ALLOW_WRITES) begin
      code_d = `AXI_RAM_RESP_SLVERR;
    end else begin
      code_d = `AXI_RAM_RESP_OKAY;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      ram_pkg::IDLE:       if (grant_wr || grant_rd) state_d = ram_pkg::MEM_ACCESS;
      ram_pkg::MEM_ACCESS: state_d = ram_pkg::RESP_WAIT;
      ram_pkg::RESP_WAIT:  if (resp_done_i) state_d = ram_pkg::IDLE;
      default:             state_d = ram_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_ni) begin
    if (!arst_ni) begin
      state_q   <= ram_pkg::IDLE;
      last_rd_q <= 1'b1;  // first tie goes to the write
      is_rd_q   <= 1'b0;
      code_q    <= `AXI_RAM_RESP_OKAY;
    end else begin
      state_q <= state_d;
      if (grant_wr || grant_rd) begin
        last_rd_q <= grant_rd;
        is_rd_q   <= grant_rd;
        code_q    <= code_d;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (grant_wr || grant_rd) begin
      addr_q  <= offset[WordLsb +: WordAw];
      wdata_q <= wdata_i;
      be_q    <= wstrb_i;
    end
  end

  // refused and out-of-range accesses never reach the array
  assign mem_req_o   = (state_q == ram_pkg::MEM_ACCESS) && (code_q == `AXI_RAM_RESP_OKAY);
  assign mem_we_o    = !is_rd_q;
  assign mem_addr_o  = addr_q;
  assign mem_wdata_o = wdata_q;
  assign mem_be_o    = be_q;

  assign resp_start_o   = (state_q == ram_pkg::MEM_ACCESS);
  assign resp_is_read_o = is_rd_q;
  assign resp_code_o    = code_q;

endmodule

`default_nettype wire

// File: ram_array.sv
`default_nettype none

`include "axi_ram_cfg.svh"

module ram_array (
  input  logic                clk_i,
  input  logic                arst_ni,
  input  logic                mem_req_i,
  input  logic                mem_we_i,
  input  ram_pkg::word_addr_t mem_addr_i,
  input  axi_lite_pkg::data_t mem_wdata_i,
  input  ram_pkg::byte_en_t   mem_be_i,
  output axi_lite_pkg::data_t mem_rdata_o
);

  localparam int unsigned NumBytes = $bits(ram_pkg::byte_en_t);

  axi_lite_pkg::data_t mem_q [`AXI_RAM_WORDS];
  axi_lite_pkg::data_t rdata_q;

  // byte lanes written under the enables
  always_ff @(posedge clk_i) begin
    if (mem_req_i && mem_we_i) begin
      for (int i = 0; i < NumBytes; i++) begin
        if (mem_be_i[i]) begin
          mem_q[mem_addr_i][8*i +: 8] <= mem_wdata_i[8*i +: 8];
        end
      end
    end
  end

  // old word, sampled before the write lands
  always_ff @(posedge clk_i or negedge arst_ni) begin
    if (!arst_ni) begin
      rdata_q <= '0;
    end else if (mem_req_i) begin
      rdata_q <= mem_q[mem_addr_i];
    end
  end

  assign mem_rdata_o = rdata_q;  // holds until the next request

endmodule

`default_nettype wire

// File: axi_resp_unit.sv
`default_nettype none

`include "axi_ram_cfg.svh"

module axi_resp_unit (
  input  logic                clk_i,
  input  logic                arst_ni,
  input  logic                resp_start_i,
  input  logic                resp_is_read_i,
  input  axi_lite_pkg::resp_t resp_code_i,
  input  axi_lite_pkg::data_t mem_rdata_i,
  input  logic                bready_i,
  input  logic                rready_i,
  output logic                bvalid_o,
  output axi_lite_pkg::resp_t bresp_o,
  output logic                rvalid_o,
  output axi_lite_pkg::data_t rdata_o,
  output axi_lite_pkg::resp_t rresp_o,
  output logic                resp_done_o
);

  logic                bvalid_q;
  logic                rvalid_q;
  axi_lite_pkg::resp_t bresp_q;
  axi_lite_pkg::resp_t rresp_q;
  logic                b_hs;
  logic                r_hs;
  logic                rd_ok;

  assign b_hs = bvalid_q && bready_i;
  assign r_hs = rvalid_q && rready_i;

  // valids: set on start, cleared by the handshake
  always_ff @(posedge clk_i or negedge arst_ni) begin
    if (!arst_ni) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (resp_start_i && !resp_is_read_i) begin
        bvalid_q <= 1'b1;
      end else if (b_hs) begin
        bvalid_q <= 1'b0;
      end
      if (resp_start_i && resp_is_read_i) begin
        rvalid_q <= 1'b1;
      end else if (r_hs) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (resp_start_i) begin
      if (resp_is_read_i) begin
        rresp_q <= resp_code_i;
      end else begin
        bresp_q <= resp_code_i;
      end
    end
  end

  assign bvalid_o = bvalid_q;
  assign bresp_o  = bresp_q;
  assign rvalid_o = rvalid_q;
  assign rresp_o  = rresp_q;

  // The array's read register is loaded at the same edge as rresp_q and stays
  // put until the next memory command, which cannot come before resp_done.
  assign rd_ok   = rvalid_q && (rresp_q == `AXI_RAM_RESP_OKAY);
  assign rdata_o = rd_ok ? mem_rdata_i : '0;  // zero on errors

  assign resp_done_o = b_hs || r_hs;

endmodule

`default_nettype wire

// File: axi_ram.sv
`default_nettype none

module axi_ram #(
  parameter bit ALLOW_WRITES = 1'b1
) (
  input  logic                clk_i,
  input  logic                arst_ni,
  input  logic                awvalid_i,
  input  axi_lite_pkg::addr_t awaddr_i,
  output logic                awready_o,
  input  logic                wvalid_i,
  input  axi_lite_pkg::data_t wdata_i,
  input  axi_lite_pkg::strb_t wstrb_i,
  output logic                wready_o,
  output logic                bvalid_o,
  output axi_lite_pkg::resp_t bresp_o,
  input  logic                bready_i,
  input  logic                arvalid_i,
  input  axi_lite_pkg::addr_t araddr_i,
  output logic                arready_o,
  output logic                rvalid_o,
  output axi_lite_pkg::data_t rdata_o,
  output axi_lite_pkg::resp_t rresp_o,
  input  logic                rready_i
);

  logic                mem_req;
  logic                mem_we;
  ram_pkg::word_addr_t mem_addr;
  axi_lite_pkg::data_t mem_wdata;
  ram_pkg::byte_en_t   mem_be;
  axi_lite_pkg::data_t mem_rdata;

  logic                resp_start;
  logic                resp_is_read;
  axi_lite_pkg::resp_t resp_code;
  logic                resp_done;

  axi_req_arbiter #(
    .ALLOW_WRITES(ALLOW_WRITES)
  ) u_arbiter (
    .clk_i         (clk_i),
    .arst_ni       (arst_ni),
    .awvalid_i     (awvalid_i),
    .awaddr_i      (awaddr_i),
    .wvalid_i      (wvalid_i),
    .wdata_i       (wdata_i),
    .wstrb_i       (wstrb_i),
    .arvalid_i     (arvalid_i),
    .araddr_i      (araddr_i),
    .awready_o     (awready_o),
    .wready_o      (wready_o),
    .arready_o     (arready_o),
    .mem_req_o     (mem_req),
    .mem_we_o      (mem_we),
    .mem_addr_o    (mem_addr),
    .mem_wdata_o   (mem_wdata),
    .mem_be_o      (mem_be),
    .resp_start_o  (resp_start),
    .resp_is_read_o(resp_is_read),
    .resp_code_o   (resp_code),
    .resp_done_i   (resp_done)
  );

  ram_array u_ram (
    .clk_i      (clk_i),
    .arst_ni    (arst_ni),
    .mem_req_i  (mem_req),
    .mem_we_i   (mem_we),
    .mem_addr_i (mem_addr),
    .mem_wdata_i(mem_wdata),
    .mem_be_i   (mem_be),
    .mem_rdata_o(mem_rdata)
  );

  axi_resp_unit u_resp (
    .clk_i         (clk_i),
    .arst_ni       (arst_ni),
    .resp_start_i  (resp_start),
    .resp_is_read_i(resp_is_read),
    .resp_code_i   (resp_code),
    .mem_rdata_i   (mem_rdata),
    .bready_i      (bready_i),
    .rready_i      (rready_i),
    .bvalid_o      (bvalid_o),
    .bresp_o       (bresp_o),
    .rvalid_o      (rvalid_o),
    .rdata_o       (rdata_o),
    .rresp_o       (rresp_o),
    .resp_done_o   (resp_done)
  );

endmodule

`default_nettype wire

// File: axi_ram_assert.sv
`default_nettype none

module axi_ram_assert (
  input wire logic                clk_i,
  input wire logic                arst_ni,
  input wire logic                awvalid_i,
  input wire axi_lite_pkg::addr_t awaddr_i,
  input wire logic                awready_o,
  input wire logic                wvalid_i,
  input wire axi_lite_pkg::data_t wdata_i,
  input wire axi_lite_pkg::strb_t wstrb_i,
  input wire logic                wready_o,
  input wire logic                bvalid_o,
  input wire axi_lite_pkg::resp_t bresp_o,
  input wire logic                bready_i,
  input wire logic                arvalid_i,
  input wire axi_lite_pkg::addr_t araddr_i,
  input wire logic                arready_o,
  input wire logic                rvalid_o,
  input wire axi_lite_pkg::data_t rdata_o,
  input wire axi_lite_pkg::resp_t rresp_o,
  input wire logic                rready_i
);

  // quiet channels in reset and one cycle past it
  quiet_in_reset: assert property (@(posedge clk_i)
    !arst_ni |-> !awready_o && !wready_o && !arready_o && !bvalid_o && !rvalid_o)
    else $error("channel active during reset");
  quiet_after_reset: assert property (@(posedge clk_i)
    $rose(arst_ni) |=> !bvalid_o && !rvalid_o)
    else $error("response valid right after reset");

  aw_hold: assert property (@(posedge clk_i) disable iff (!arst_ni)
    awvalid_i && !awready_o |=> awvalid_i && $stable(awaddr_i))
    else $error("write address dropped before ready");
  w_hold: assert property (@(posedge clk_i) disable iff (!arst_ni)
    wvalid_i && !wready_o |=> wvalid_i && $stable(wdata_i) && $stable(wstrb_i))
    else $error("write data dropped before ready");
  ar_hold: assert property (@(posedge clk_i) disable iff (!arst_ni)
    arvalid_i && !arready_o |=> arvalid_i && $stable(araddr_i))
    else $error("read address dropped before ready");

  b_stable: assert property (@(posedge clk_i) disable iff (!arst_ni)
    bvalid_o && !bready_i |=> bvalid_o && $stable(bresp_o))
    else $error("write response changed while pending");
  r_stable: assert property (@(posedge clk_i) disable iff (!arst_ni)
    rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o) && $stable(rresp_o))
    else $error("read response changed while pending");

  b_latency: assert property (@(posedge clk_i) disable iff (!arst_ni)
    awvalid_i && awready_o |-> ##2 $rose(bvalid_o))
    else $error("bvalid not 2 cycles after acceptance");
  r_latency: assert property (@(posedge clk_i) disable iff (!arst_ni)
    arvalid_i && arready_o |-> ##2 $rose(rvalid_o))
    else $error("rvalid not 2 cycles after acceptance");

  no_accept_pending: assert property (@(posedge clk_i) disable iff (!arst_ni)
    bvalid_o || rvalid_o |-> !awready_o && !wready_o && !arready_o)
    else $error("request accepted while a response is pending");

endmodule

bind axi_ram axi_ram_assert u_assert (
  .clk_i(clk_i), .arst_ni(arst_ni),
  .awvalid_i(awvalid_i), .awaddr_i(awaddr_i), .awready_o(awready_o),
  .wvalid_i(wvalid_i), .wdata_i(wdata_i), .wstrb_i(wstrb_i), .wready_o(wready_o),
  .bvalid_o(bvalid_o), .bresp_o(bresp_o), .bready_i(bready_i),
  .arvalid_i(arvalid_i), .araddr_i(araddr_i), .arready_o(arready_o),
  .rvalid_o(rvalid_o), .rdata_o(rdata_o), .rresp_o(rresp_o), .rready_i(rready_i)
);

`default_nettype wire

// File: tb_axi_ram.sv
`default_nettype none

`include "axi_ram_cfg.svh"

module tb_axi_ram;

  localparam axi_lite_pkg::addr_t Base = axi_lite_pkg::addr_t'(`AXI_RAM_BASE);
  localparam int Span = `AXI_RAM_WORDS * 4;
  localparam int Limit = 50;

  logic clk_i;
  logic arst_ni;

  // index 0 drives DUT, index 1 drives DUT_RO
  logic awvalid [2];
  logic wvalid [2];
  logic arvalid [2];
  logic bready [2];
  logic rready [2];
  axi_lite_pkg::addr_t awaddr [2];
  axi_lite_pkg::addr_t araddr [2];
  axi_lite_pkg::data_t wdata [2];
  axi_lite_pkg::strb_t wstrb [2];
  logic awready [2];
  logic wready [2];
  logic arready [2];
  logic bvalid [2];
  logic rvalid [2];
  axi_lite_pkg::resp_t bresp [2];
  axi_lite_pkg::resp_t rresp [2];
  axi_lite_pkg::data_t rdata [2];

  logic [7:0] shadow [Span];  // reference bytes of DUT
  int errors;
  int timeouts;
  int last_kind [2];  // 0 write, 1 read, -1 none yet

  always #50 clk_i = ~clk_i;

  axi_ram #(.ALLOW_WRITES(1'b1)) DUT (
    .clk_i(clk_i), .arst_ni(arst_ni),
    .awvalid_i(awvalid[0]), .awaddr_i(awaddr[0]), .awready_o(awready[0]),
    .wvalid_i(wvalid[0]), .wdata_i(wdata[0]), .wstrb_i(wstrb[0]), .wready_o(wready[0]),
    .bvalid_o(bvalid[0]), .bresp_o(bresp[0]), .bready_i(bready[0]),
    .arvalid_i(arvalid[0]), .araddr_i(araddr[0]), .arready_o(arready[0]),
    .rvalid_o(rvalid[0]), .rdata_o(rdata[0]), .rresp_o(rresp[0]), .rready_i(rready[0])
  );

  axi_ram #(.ALLOW_WRITES(1'b0)) DUT_RO (
    .clk_i(clk_i), .arst_ni(arst_ni),
    .awvalid_i(awvalid[1]), .awaddr_i(awaddr[1]), .awready_o(awready[1]),
    .wvalid_i(wvalid[1]), .wdata_i(wdata[1]), .wstrb_i(wstrb[1]), .wready_o(wready[1]),
    .bvalid_o(bvalid[1]), .bresp_o(bresp[1]), .bready_i(bready[1]),
    .arvalid_i(arvalid[1]), .araddr_i(araddr[1]), .arready_o(arready[1]),
    .rvalid_o(rvalid[1]), .rdata_o(rdata[1]), .rresp_o(rresp[1]), .rready_i(rready[1])
  );

  task automatic next_slot();
    @(posedge clk_i);
    #10;
  endtask

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    $display("timeout at %0t: %s did not arrive within %0d cycles", $time, what, Limit);
  endtask

  function automatic axi_lite_pkg::data_t ref_word(input axi_lite_pkg::addr_t addr);
    int off;
    off = int'(addr - Base);
    return {shadow[off+3], shadow[off+2], shadow[off+1], shadow[off]};
  endfunction

  function automatic axi_lite_pkg::addr_t word_addr(input int w);
    return Base + axi_lite_pkg::addr_t'(w * 4);
  endfunction

  task automatic update_shadow(input axi_lite_pkg::addr_t addr, input axi_lite_pkg::data_t data,
                               input axi_lite_pkg::strb_t strb);
    int off;
    off = int'(addr - Base);
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) shadow[off+i] = data[8*i +: 8];
    end
  endtask

  // latency counted in negedges after the accepting edge
  task automatic wait_response(input int d, input bit is_rd, output bit ok);
    int n;
    ok = 0;
    n = 0;
    while (!ok && n < Limit) begin
      @(negedge clk_i);
      n++;
      if (is_rd ? rvalid[d] : bvalid[d]) ok = 1;
    end
    if (!ok) report_timeout(is_rd ? "rvalid" : "bvalid");
    else check_val(is_rd ? "rvalid latency" : "bvalid latency", 2, n);
  endtask

  task automatic write_req(input int d, input axi_lite_pkg::addr_t addr,
                           input axi_lite_pkg::data_t data, input axi_lite_pkg::strb_t strb,
                           input axi_lite_pkg::resp_t exp_resp, input int delay);
    int n;
    bit ok;
    awvalid[d] = 1'b1;
    awaddr[d] = addr;
    wvalid[d] = 1'b1;
    wdata[d] = data;
    wstrb[d] = strb;
    ok = 0;
    n = 0;
    while (!ok && n < Limit) begin
      @(negedge clk_i);
      n++;
      if (awready[d] && wready[d]) ok = 1;
    end
    next_slot();
    awvalid[d] = 1'b0;
    wvalid[d] = 1'b0;
    if (!ok) begin
      report_timeout("awready and wready");
      return;
    end
    wait_response(d, 1'b0, ok);
    if (!ok) return;
    repeat (delay) @(negedge clk_i);
    check_val("bvalid", 1, 32'(bvalid[d]));
    check_val("bresp", 32'(exp_resp), 32'(bresp[d]));
    next_slot();
    bready[d] = 1'b1;
    next_slot();
    bready[d] = 1'b0;
    check_val("bvalid", 0, 32'(bvalid[d]));
    last_kind[d] = 0;
    if (d == 0 && exp_resp == `AXI_RAM_RESP_OKAY) update_shadow(addr, data, strb);
  endtask

  task automatic read_req(input int d, input axi_lite_pkg::addr_t addr,
                          input axi_lite_pkg::resp_t exp_resp, input int delay,
                          output axi_lite_pkg::data_t got);
    int n;
    bit ok;
    got = '0;
    arvalid[d] = 1'b1;
    araddr[d] = addr;
    ok = 0;
    n = 0;
    while (!ok && n < Limit) begin
      @(negedge clk_i);
      n++;
      if (arready[d]) ok = 1;
    end
    next_slot();
    arvalid[d] = 1'b0;
    if (!ok) begin
      report_timeout("arready");
      return;
    end
    wait_response(d, 1'b1, ok);
    if (!ok) return;
    repeat (delay) @(negedge clk_i);
    check_val("rvalid", 1, 32'(rvalid[d]));
    check_val("rresp", 32'(exp_resp), 32'(rresp[d]));
    got = rdata[d];
    next_slot();
    rready[d] = 1'b1;
    next_slot();
    rready[d] = 1'b0;
    check_val("rvalid", 0, 32'(rvalid[d]));
    last_kind[d] = 1;
  endtask

  // write and read offered together on DUT, to different words
  task automatic both_req(input axi_lite_pkg::addr_t waddr, input axi_lite_pkg::data_t data,
                          input axi_lite_pkg::strb_t strb, input axi_lite_pkg::addr_t raddr);
    int n;
    int first;
    bit done_w;
    bit done_r;
    bit acc_w;
    bit acc_r;
    axi_lite_pkg::data_t exp_rd;
    exp_rd = ref_word(raddr);
    first = -1;
    done_w = 0;
    done_r = 0;
    awvalid[0] = 1'b1;
    awaddr[0] = waddr;
    wvalid[0] = 1'b1;
    wdata[0] = data;
    wstrb[0] = strb;
    arvalid[0] = 1'b1;
    araddr[0] = raddr;
    bready[0] = 1'b1;
    rready[0] = 1'b1;
    n = 0;
    while (!(done_w && done_r) && n < Limit) begin
      @(negedge clk_i);
      n++;
      acc_w = awready[0] && wready[0];
      acc_r = arready[0];
      if (first < 0 && (acc_w || acc_r)) first = acc_r ? 1 : 0;
      if (bvalid[0]) begin
        check_val("bresp", 32'(`AXI_RAM_RESP_OKAY), 32'(bresp[0]));
        done_w = 1;
      end
      if (rvalid[0]) begin
        check_val("rresp", 32'(`AXI_RAM_RESP_OKAY), 32'(rresp[0]));
        check_val("rdata", exp_rd, rdata[0]);
        done_r = 1;
      end
      next_slot();
      if (acc_w) awvalid[0] = 1'b0;
      if (acc_w) wvalid[0] = 1'b0;
      if (acc_r) arvalid[0] = 1'b0;
    end
    awvalid[0] = 1'b0;
    wvalid[0] = 1'b0;
    arvalid[0] = 1'b0;
    bready[0] = 1'b0;
    rready[0] = 1'b0;
    if (!(done_w && done_r)) begin
      report_timeout("both responses of a simultaneous write and read");
      return;
    end
    if (last_kind[0] >= 0) check_val("first granted kind", 1 - last_kind[0], first);
    last_kind[0] = 1 - first;
    update_shadow(waddr, data, strb);
  endtask

  initial begin
    axi_lite_pkg::data_t v1;
    axi_lite_pkg::data_t v2;
    axi_lite_pkg::strb_t strb;
    int w;
    void'($urandom(25262));
    clk_i = 1'b0;
    arst_ni = 1'b0;
    errors = 0;
    timeouts = 0;
    for (int d = 0; d < 2; d++) begin
      awvalid[d] = 1'b0;
      wvalid[d] = 1'b0;
      arvalid[d] = 1'b0;
      bready[d] = 1'b0;
      rready[d] = 1'b0;
      awaddr[d] = '0;
      araddr[d] = '0;
      wdata[d] = '0;
      wstrb[d] = '0;
      last_kind[d] = -1;
    end
    repeat (2) @(posedge clk_i);
    #10 arst_ni = 1'b1;

    // idle after reset
    repeat (3) begin
      @(negedge clk_i);
      for (int d = 0; d < 2; d++) begin
        check_val("awready", 0, 32'(awready[d]));
        check_val("wready", 0, 32'(wready[d]));
        check_val("arready", 0, 32'(arready[d]));
        check_val("bvalid", 0, 32'(bvalid[d]));
        check_val("rvalid", 0, 32'(rvalid[d]));
      end
    end
    next_slot();

    for (int i = 0; i < 16; i++) write_req(0, word_addr(i), $urandom, 4'hF, `AXI_RAM_RESP_OKAY, 0);

    repeat (40) begin
      w = int'($urandom % 16);
      strb = axi_lite_pkg::strb_t'($urandom);
      write_req(0, word_addr(w), $urandom, strb, `AXI_RAM_RESP_OKAY, int'($urandom % 4));
      read_req(0, word_addr(w), `AXI_RAM_RESP_OKAY, int'($urandom % 4), v1);
      check_val("rdata", ref_word(word_addr(w)), v1);
      read_req(0, word_addr((w + 1) % 16), `AXI_RAM_RESP_OKAY, 0, v1);
      check_val("rdata", ref_word(word_addr((w + 1) % 16)), v1);
    end

    // outside the window
    write_req(0, Base - 4, $urandom, 4'hF, `AXI_RAM_RESP_DECERR, 1);
    write_req(0, word_addr(`AXI_RAM_WORDS), $urandom, 4'hF, `AXI_RAM_RESP_DECERR, 0);
    read_req(0, Base - 4, `AXI_RAM_RESP_DECERR, 2, v1);
    check_val("rdata", 0, v1);
    read_req(0, word_addr(`AXI_RAM_WORDS + 3), `AXI_RAM_RESP_DECERR, 0, v1);
    check_val("rdata", 0, v1);
    for (int i = 0; i < 16; i++) begin
      read_req(0, word_addr(i), `AXI_RAM_RESP_OKAY, 0, v1);
      check_val("rdata", ref_word(word_addr(i)), v1);
    end

    // read-only instance refuses writes
    for (int i = 0; i < 4; i++) begin
      read_req(1, word_addr(i), `AXI_RAM_RESP_OKAY, 0, v1);
      write_req(1, word_addr(i), $urandom, 4'hF, `AXI_RAM_RESP_SLVERR, int'($urandom % 3));
      read_req(1, word_addr(i), `AXI_RAM_RESP_OKAY, 0, v2);
      check_val("DUT_RO rdata", v1, v2);
    end

    for (int i = 0; i < 10; i++) begin
      w = int'($urandom % 8);
      // a lone read or write first, so both tie-break directions come up
      if (i % 2 == 0) begin
        read_req(0, word_addr(w + 8), `AXI_RAM_RESP_OKAY, 0, v1);
        check_val("rdata", ref_word(word_addr(w + 8)), v1);
      end else begin
        write_req(0, word_addr(w), $urandom, 4'hF, `AXI_RAM_RESP_OKAY, 0);
      end
      both_req(word_addr(w), $urandom, axi_lite_pkg::strb_t'($urandom), word_addr(w + 8));
    end

    $display("closing: %0d check errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
+incdir+.
axi_lite_pkg.sv
ram_pkg.sv
axi_req_arbiter.sv
ram_array.sv
axi_resp_unit.sv
axi_ram.sv
axi_ram_assert.sv
tb_axi_ram.sv

// File: run.sh
#!/bin/sh
# build and run the testbench, pass only if the pass message shows up
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_axi_ram -f files.f -o sim_axi_ram \
  && ./obj_dir/sim_axi_ram | grep "Everything OK" \
  && exit 0 \
  || exit 1
